//--- conv_afu_pkg.sv
// cache-line copy engine definitions
`default_nettype none

package conv_afu_pkg;

  // cache-line address, byte address without the 6 offset bits
  localparam int ADDR_WIDTH = 58;
  localparam int CL_WIDTH = 512;
  localparam int COUNT_WIDTH = 32;
  localparam int CTX_WIDTH = 512;

  // field positions inside the control context
  // source and destination are byte addresses, 64 bits each
  localparam int CTX_SRC_LSB = 64;
  localparam int CTX_LEN_LSB = 192;
  localparam int CTX_DST_LSB = 448;

  typedef logic [ADDR_WIDTH-1:0] cl_addr_t;
  typedef logic [CL_WIDTH-1:0] cl_data_t;
  typedef logic [COUNT_WIDTH-1:0] line_count_t;

  // read request toward memory
  typedef struct packed {
    logic en;
    cl_addr_t addr;
  } rd_req_t;

  // read response from memory, in request order
  typedef struct packed {
    logic valid;
    cl_data_t data;
  } rd_rsp_t;

  // write request toward memory
  typedef struct packed {
    logic en;
    cl_addr_t addr;
    cl_data_t data;
  } wr_req_t;

endpackage

`default_nettype wire

//--- cl_sync_fifo.sv
// synchronous FIFO with typed payload
`timescale 1ns/1ps
`default_nettype none

module cl_sync_fifo #(
  parameter int DEPTH_BITS = 3,
  parameter type payload_t = logic [7:0]
) (
  input wire clk,
  input wire reset,
  input wire push,
  input wire payload_t push_data,
  input wire pop,
  output payload_t pop_data,
  output logic empty,
  output logic [DEPTH_BITS:0] count
);

  localparam int DEPTH = 2 ** DEPTH_BITS;

  payload_t mem [DEPTH];

  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic full;
  logic do_push;
  logic do_pop;

  assign empty = (count == '0);
  assign full = (count == (DEPTH_BITS + 1)'(DEPTH));

  // overflow and underflow requests are dropped
  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  // storage and registered read port
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
    if (do_pop) begin
      pop_data <= mem[rd_ptr];
    end
  end

  // pointers wrap at the power-of-two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cl_read_requester.sv
// cache-line read requester
`timescale 1ns/1ps
`default_nettype none

module cl_read_requester #(
  parameter int FIFO_DEPTH_BITS = 3
) (
  input wire clk,
  input wire reset,
  input wire start,
  input wire [conv_afu_pkg::CTX_WIDTH-1:0] afu_context,
  input wire rd_req_almostfull,
  input wire conv_afu_pkg::rd_rsp_t rd_rsp,
  input wire [FIFO_DEPTH_BITS:0] fifo_count,
  output conv_afu_pkg::rd_req_t rd_req,
  output logic push,
  output conv_afu_pkg::cl_data_t push_data,
  output logic job_start,
  output conv_afu_pkg::cl_addr_t dst_base,
  output conv_afu_pkg::line_count_t job_lines
);

  import conv_afu_pkg::*;

  // bytes per line as address bits
  localparam int OFFSET_BITS = 6;
  localparam logic [FIFO_DEPTH_BITS+1:0] DEPTH = (FIFO_DEPTH_BITS + 2)'(2 ** FIFO_DEPTH_BITS);

  typedef enum logic {
    ST_IDLE,
    ST_READ
  } state_t;

  state_t state;

  cl_addr_t src_addr;
  line_count_t issued;
  logic rd_en_q;
  cl_addr_t rd_addr_q;

  // lines requested but not yet pushed into the FIFO
  logic [FIFO_DEPTH_BITS:0] in_flight;
  logic [FIFO_DEPTH_BITS+1:0] credit_used;
  logic credit_ok;
  logic issue;

  // in-flight plus buffered lines must stay below the FIFO depth
  assign credit_used = {1'b0, in_flight} + {1'b0, fifo_count};
  assign credit_ok = credit_used < DEPTH;

  assign issue = (state == ST_READ) && (issued != job_lines) &&
                 !rd_req_almostfull && credit_ok;

  // job FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      issued <= '0;
      rd_en_q <= 1'b0;
      job_start <= 1'b0;
      job_lines <= '0;
    end else begin
      job_start <= 1'b0;
      rd_en_q <= issue;
      case (state)
        ST_IDLE: begin
          if (start) begin
            job_lines <= afu_context[CTX_LEN_LSB +: COUNT_WIDTH];
            issued <= '0;
            job_start <= 1'b1;
            state <= ST_READ;
          end
        end
        ST_READ: begin
          if (issued == job_lines) begin
            state <= ST_IDLE;
          end else if (issue) begin
            issued <= issued + 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // job addresses, latched on start and walked per request
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      src_addr <= afu_context[CTX_SRC_LSB + OFFSET_BITS +: ADDR_WIDTH];
      dst_base <= afu_context[CTX_DST_LSB + OFFSET_BITS +: ADDR_WIDTH];
    end else if (issue) begin
      src_addr <= src_addr + 1'b1;
    end
    if (issue) begin
      rd_addr_q <= src_addr;
    end
  end

  assign rd_req.en = rd_en_q;
  assign rd_req.addr = rd_addr_q;

  // registered capture of read responses
  always_ff @(posedge clk) begin
    if (reset) begin
      push <= 1'b0;
    end else begin
      push <= rd_rsp.valid;
    end
  end

  always_ff @(posedge clk) begin
    push_data <= rd_rsp.data;
  end

  // a line leaves the in-flight count once it is pushed
  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + (FIFO_DEPTH_BITS + 1)'(issue) - (FIFO_DEPTH_BITS + 1)'(push);
    end
  end

endmodule

`default_nettype wire

//--- cl_write_requester.sv
// cache-line write requester
`timescale 1ns/1ps
`default_nettype none

module cl_write_requester (
  input wire clk,
  input wire reset,
  input wire wr_req_almostfull,
  input wire empty,
  input wire conv_afu_pkg::cl_data_t pop_data,
  input wire job_start,
  input wire conv_afu_pkg::cl_addr_t dst_base,
  input wire conv_afu_pkg::line_count_t job_lines,
  output logic pop,
  output conv_afu_pkg::wr_req_t wr_req,
  output logic done
);

  import conv_afu_pkg::*;

  line_count_t wr_count;
  logic wr_en_q;
  cl_addr_t wr_addr_q;
  // set by the first job, keeps done low out of reset
  logic armed;

  assign pop = !wr_req_almostfull && !empty;

  // popped line is on pop_data the cycle after the pop
  assign wr_req.en = wr_en_q;
  assign wr_req.addr = wr_addr_q;
  assign wr_req.data = pop_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en_q <= 1'b0;
      wr_count <= '0;
      armed <= 1'b0;
      done <= 1'b0;
    end else begin
      wr_en_q <= pop;
      if (job_start) begin
        wr_count <= '0;
        armed <= 1'b1;
        done <= 1'b0;
      end else begin
        if (pop) begin
          wr_count <= wr_count + 1'b1;
        end
        done <= armed && (wr_count == job_lines);
      end
    end
  end

  // write k lands at dst_base + k
  always_ff @(posedge clk) begin
    if (pop) begin
      wr_addr_q <= dst_base + cl_addr_t'(wr_count);
    end
  end

endmodule

`default_nettype wire

//--- conv_afu_top.sv
// cache-line copy engine top level
`timescale 1ns/1ps
`default_nettype none

module conv_afu_top #(
  parameter int FIFO_DEPTH_BITS = 3
) (
  input wire clk,
  input wire reset,
  input wire start,
  input wire [conv_afu_pkg::CTX_WIDTH-1:0] afu_context,
  input wire rd_req_almostfull,
  input wire conv_afu_pkg::rd_rsp_t rd_rsp,
  input wire wr_req_almostfull,
  output conv_afu_pkg::rd_req_t rd_req,
  output conv_afu_pkg::wr_req_t wr_req,
  output logic done
);

  import conv_afu_pkg::*;

  // producer to buffer
  logic push;
  cl_data_t push_data;

  // buffer to consumer
  logic pop;
  cl_data_t pop_data;
  logic empty;
  logic [FIFO_DEPTH_BITS:0] fifo_count;

  // job description, stable from start to the next start
  logic job_start;
  cl_addr_t dst_base;
  line_count_t job_lines;

  cl_read_requester #(
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) i_cl_read_requester (
    .clk(clk),
    .reset(reset),
    .start(start),
    .afu_context(afu_context),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp(rd_rsp),
    .fifo_count(fifo_count),
    .rd_req(rd_req),
    .push(push),
    .push_data(push_data),
    .job_start(job_start),
    .dst_base(dst_base),
    .job_lines(job_lines)
  );

  // output buffer between read responses and write requests
  cl_sync_fifo #(
    .DEPTH_BITS(FIFO_DEPTH_BITS),
    .payload_t(cl_data_t)
  ) i_cl_sync_fifo (
    .clk(clk),
    .reset(reset),
    .push(push),
    .push_data(push_data),
    .pop(pop),
    .pop_data(pop_data),
    .empty(empty),
    .count(fifo_count)
  );

  cl_write_requester i_cl_write_requester (
    .clk(clk),
    .reset(reset),
    .wr_req_almostfull(wr_req_almostfull),
    .empty(empty),
    .pop_data(pop_data),
    .job_start(job_start),
    .dst_base(dst_base),
    .job_lines(job_lines),
    .pop(pop),
    .wr_req(wr_req),
    .done(done)
  );

endmodule

`default_nettype wire

//--- tb_conv_afu.sv
// copy engine testbench
`timescale 1ns/1ps
`default_nettype none

module tb_conv_afu;

  import conv_afu_pkg::*;

  localparam int FIFO_DEPTH_BITS = 3;
  localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;
  localparam int MAX_CASES = 64;
  // context positions of the byte addresses and the 32-bit line count
  localparam int SRC_LSB = 64;
  localparam int LEN_LSB = 192;
  localparam int DST_LSB = 448;

  logic clk;
  logic reset;
  logic start;
  logic [511:0] afu_context;
  logic rd_req_almostfull;
  logic wr_req_almostfull;
  rd_rsp_t rd_rsp;
  rd_req_t rd_req;
  wr_req_t wr_req;
  logic done;

  integer seed = 29;
  int cycle = 0;

  // jobs from the cases file
  logic [63:0] case_src [MAX_CASES];
  int case_len [MAX_CASES];
  logic [63:0] case_dst [MAX_CASES];
  int case_mode [MAX_CASES];
  int num_cases = 0;
  logic cases_loaded = 1'b0;

  // current job as tracked by the monitor
  int case_idx = 0;
  int bp_mode = 0;
  logic any_start = 1'b0;
  logic complete = 1'b0;
  logic [57:0] exp_src_line = '0;
  logic [57:0] exp_dst_line = '0;
  int exp_len = 0;
  int rd_count = 0;
  int wr_count = 0;
  int total_reads = 0;
  int total_writes = 0;
  logic prev_done = 1'b0;
  logic prev_rd_af = 1'b0;
  logic prev_wr_af = 1'b0;

  // memory model answering in request order
  logic [57:0] rsp_addr_q[$];
  int rsp_due_q[$];
  int last_due = 0;

  conv_afu_top #(
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) i_conv_afu_top (
    .clk(clk),
    .reset(reset),
    .start(start),
    .afu_context(afu_context),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp(rd_rsp),
    .wr_req_almostfull(wr_req_almostfull),
    .rd_req(rd_req),
    .wr_req(wr_req),
    .done(done)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // line a holds a repeated over all 512 bits
  function automatic logic [511:0] line_pattern(input logic [57:0] a);
    logic [511:0] d;
    for (int i = 0; i < 512; i++) begin
      d[i] = a[i % 58];
    end
    return d;
  endfunction

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at cycle %0d", cycle);
  endtask

  task automatic check_value(input string name, input logic [511:0] expected,
                             input logic [511:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    abort_run();
  endtask

  // read responses after 1 to 4 cycles and at most one per cycle
  initial begin
    rd_rsp = '0;
    forever begin
      @(negedge clk);
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
        rd_rsp.valid = 1'b1;
        rd_rsp.data = line_pattern(rsp_addr_q.pop_front());
        void'(rsp_due_q.pop_front());
      end else begin
        rd_rsp = '0;
      end
    end
  end

  // back-pressure per case mode
  initial begin
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    forever begin
      @(negedge clk);
      rd_req_almostfull = (bp_mode != 0) && (($random(seed) & 3) == 0);
      if (bp_mode == 1) begin
        wr_req_almostfull = ($random(seed) & 1) == 1;
      end else begin
        // mode 2 keeps the write side blocked most of the time
        wr_req_almostfull = (bp_mode == 2) && ((cycle % 40) >= 5);
      end
    end
  end

  always @(posedge clk) begin : monitor
    logic [57:0] exp_addr;
    int rsp_delay;
    cycle = cycle + 1;
    if (!any_start && cycle > 1) begin
      check_value("idle rd_req.en", 512'(0), 512'(rd_req.en));
      check_value("idle wr_req.en", 512'(0), 512'(wr_req.en));
      check_value("idle done", 512'(0), 512'(done));
    end
    if (prev_rd_af && rd_req.en) begin
      report_failure("read request issued right after rd_req_almostfull was high");
    end
    if (prev_wr_af && wr_req.en) begin
      report_failure("write request issued right after wr_req_almostfull was high");
    end
    if (done && (rd_req.en || wr_req.en)) begin
      report_failure("request issued while done was high");
    end
    if (complete && !done) begin
      report_failure("done dropped before the next start");
    end
    if (rd_req.en) begin
      if (rd_count >= exp_len) begin
        report_failure($sformatf("case %0d issued more than %0d reads", case_idx, exp_len));
      end
      exp_addr = exp_src_line + 58'(rd_count);
      check_value($sformatf("case %0d read %0d address", case_idx, rd_count),
                  512'(exp_addr), 512'(rd_req.addr));
      rsp_addr_q.push_back(rd_req.addr);
      rsp_delay = 1 + ($random(seed) & 3);
      if (cycle + rsp_delay > last_due) begin
        last_due = cycle + rsp_delay;
      end
      rsp_due_q.push_back(last_due);
      rd_count = rd_count + 1;
      total_reads = total_reads + 1;
    end
    if (wr_req.en) begin
      if (wr_count >= exp_len) begin
        report_failure($sformatf("case %0d issued more than %0d writes", case_idx, exp_len));
      end
      exp_addr = exp_dst_line + 58'(wr_count);
      check_value($sformatf("case %0d write %0d address", case_idx, wr_count),
                  512'(exp_addr), 512'(wr_req.addr));
      check_value($sformatf("case %0d write %0d data", case_idx, wr_count),
                  line_pattern(exp_src_line + 58'(wr_count)), wr_req.data);
      wr_count = wr_count + 1;
      total_writes = total_writes + 1;
    end
    if (total_reads - total_writes > DEPTH) begin
      report_failure($sformatf("%0d lines outstanding, more than the FIFO depth",
                               total_reads - total_writes));
    end
    // done rising marks the end of the job
    if (any_start && !prev_done && done) begin
      check_value($sformatf("case %0d read count", case_idx), 512'(exp_len), 512'(rd_count));
      check_value($sformatf("case %0d write count", case_idx), 512'(exp_len), 512'(wr_count));
      complete = 1'b1;
    end
    prev_done = done;
    prev_rd_af = rd_req_almostfull;
    prev_wr_af = wr_req_almostfull;
  end

  initial begin
    int fd;
    int n;
    string line;
    logic [63:0] src;
    logic [63:0] dst;
    int len;
    int mode;
    reset = 1'b1;
    start = 1'b0;
    afu_context = '0;
    fd = $fopen("afu_cases.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open afu_cases.txt");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%h %d %h %d", src, len, dst, mode);
      if (n == 4) begin
        if (num_cases < MAX_CASES) begin
          case_src[num_cases] = src;
          case_len[num_cases] = len;
          case_dst[num_cases] = dst;
          case_mode[num_cases] = mode;
          num_cases = num_cases + 1;
        end
      end else begin
        // comment line or trailing text
        n = $fgets(line, fd);
      end
    end
    $fclose(fd);
    if (num_cases == 0) begin
      report_failure("afu_cases.txt holds no jobs");
    end
    cases_loaded = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);
    for (int c = 0; c < num_cases; c++) begin
      @(negedge clk);
      case_idx = c;
      bp_mode = case_mode[c];
      exp_src_line = case_src[c][63:6];
      exp_dst_line = case_dst[c][63:6];
      exp_len = case_len[c];
      rd_count = 0;
      wr_count = 0;
      complete = 1'b0;
      any_start = 1'b1;
      // unused context bits carry noise
      for (int w = 0; w < 16; w++) begin
        afu_context[w*32 +: 32] = $random(seed);
      end
      afu_context[SRC_LSB +: 64] = case_src[c];
      afu_context[LEN_LSB +: 32] = case_len[c];
      afu_context[DST_LSB +: 64] = case_dst[c];
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      afu_context = ~afu_context;
      while (!complete) begin
        @(negedge clk);
      end
      // done has to hold while idle
      repeat (6) @(negedge clk);
    end
    if (total_reads != total_writes || rsp_addr_q.size() != 0) begin
      report_failure("reads and writes do not balance at the end of the run");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  // watchdog allows 200 cycles per line plus a margin
  initial begin
    int limit;
    wait (cases_loaded === 1'b1);
    limit = 500 + 100 * num_cases;
    for (int c = 0; c < num_cases; c++) begin
      limit = limit + 200 * case_len[c];
    end
    repeat (limit) @(posedge clk);
    $display("timeout: jobs not finished within %0d cycles", limit);
    abort_run();
  end

endmodule

`default_nettype wire

//--- afu_cases.txt
# columns: source byte address (hex), line count (decimal), destination byte address (hex),
# back-pressure mode (0 none, 1 random on both sides, 2 write side held high in long stretches)
0000000000001000 4 0000000000100000 0
0000000000002000 1 0000000000200000 0
0000000000003000 0 0000000000300000 0
0000000000004000 16 0000000000400000 0
0000000000005028 3 00000000005000c0 0
ffffffffffffff00 8 0000000000600000 0
0000000000007000 12 0000000000700000 1
0000000000008000 1 0000000000800000 1
000000000009a000 0 0000000000900000 1
0000000000010000 24 0000000000a00000 1
0000000000020000 40 0000000000b00000 2
0000000000030000 5 0000000000c00000 2
00000000abcde000 32 00000000fedc0000 2
0000000000040000 9 0000000000d00000 0

//--- sources.f
conv_afu_pkg.sv
cl_sync_fifo.sv
cl_read_requester.sv
cl_write_requester.sv
conv_afu_top.sv
tb_conv_afu.sv

//--- Makefile
# Verilator build and run of the copy engine testbench

VERILATOR ?= verilator
TOP ?= tb_conv_afu
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
